/* bench/test_controller_assertions.sv */
// Concurrent protocol checks on the controller's FIFO ports and result flags
`timescale 1ns/10ps

module test_controller_assertions (
    input logic       clk,
    input logic       reset_i,
    input logic       in_empty_i,
    input logic       in_rd_en_o,
    input logic       out_full_i,
    input logic       out_wr_en_o,
    input logic [7:0] out_data_o,
    input logic       test_ok_o,
    input logic       test_fail_o
);

    // ======================================================================
    // FIFO handshakes
    // ======================================================================

    // No write into a full output FIFO
    write_when_full: assert property (
        @(posedge clk) disable iff (reset_i) !(out_wr_en_o && out_full_i)
    ) else $error("out_wr_en_o high while out_full_i is high");

    // No read from an empty input FIFO
    read_when_empty: assert property (
        @(posedge clk) disable iff (reset_i) !(in_rd_en_o && in_empty_i)
    ) else $error("in_rd_en_o high while in_empty_i is high");

    // Written bytes fully defined
    data_known: assert property (
        @(posedge clk) disable iff (reset_i) out_wr_en_o |-> !$isunknown(out_data_o)
    ) else $error("out_data_o has unknown bits on a write");

    // ======================================================================
    // Result flags
    // ======================================================================

    // One result at a time
    ok_and_fail: assert property (
        @(posedge clk) disable iff (reset_i) !(test_ok_o && test_fail_o)
    ) else $error("test_ok_o and test_fail_o high together");

endmodule

/* bench/test_controller_tb.sv */
// Testbench with clock, reset, FIFO models, LFSR back-pressure, stimulus and value checks
`timescale 1ns/10ps

module test_controller_tb;
    import test_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic        clk = 1'b0;
    logic        reset_i = 1'b1;
    logic        in_empty_i = 1'b1;
    logic [7:0]  in_data_i = 8'h00;
    logic        out_full_i = 1'b0;
    logic        in_rd_en_o;
    logic        out_wr_en_o;
    logic [7:0]  out_data_o;
    logic        test_ok_o;
    logic        test_fail_o;

    logic [7:0]  in_q[$];
    logic [7:0]  out_q[$];
    logic [7:0]  exp_q[$];
    logic [15:0] lfsr_q = 16'd43;
    logic        random_full = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errs_at_start = 0;
    int          level;

    test_controller #(
        .PAYLOAD_LEN  (4),
        .PACKET_COUNT (2)
    ) test_controller_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_empty_i  (in_empty_i),
        .in_data_i   (in_data_i),
        .in_rd_en_o  (in_rd_en_o),
        .out_full_i  (out_full_i),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o),
        .test_ok_o   (test_ok_o),
        .test_fail_o (test_fail_o)
    );

    bind test_controller test_controller_assertions test_controller_assertions_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_empty_i  (in_empty_i),
        .in_rd_en_o  (in_rd_en_o),
        .out_full_i  (out_full_i),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o),
        .test_ok_o   (test_ok_o),
        .test_fail_o (test_fail_o)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Header byte as command over length
    function automatic logic [7:0] make_header(input logic [1:0] cmd, input int len);
        return {cmd, LEN_W'(len)};
    endfunction

    // ======================================================================
    // FIFO models
    // ======================================================================

    // Read and write both complete on the rising edge
    always @(posedge clk) begin
        if (in_rd_en_o && in_q.size() > 0) begin
            in_q.delete(0);
        end
        if (out_wr_en_o) begin
            out_q.push_back(out_data_o);
        end
    end

    // Input FIFO head shown before the read and the random full flag
    always @(negedge clk) begin
        in_empty_i <= (in_q.size() == 0);
        in_data_i  <= (in_q.size() > 0) ? in_q[0] : 8'h00;
        if (random_full) begin
            out_full_i <= lfsr_q[0];
            lfsr_q     <= lfsr_step(lfsr_q);
        end else begin
            out_full_i <= 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_controls_low();
        check_value("in_rd_en_o", 8'(in_rd_en_o), 8'h00);
        check_value("out_wr_en_o", 8'(out_wr_en_o), 8'h00);
        check_value("test_ok_o", 8'(test_ok_o), 8'h00);
        check_value("test_fail_o", 8'(test_fail_o), 8'h00);
    endtask

    // Reset for 4 cycles with empty FIFOs and controls checked throughout
    task automatic apply_reset();
        in_q.delete();
        random_full = 1'b0;
        @(negedge clk);
        reset_i <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_controls_low();
        end
        reset_i <= 1'b0;
        out_q.delete();
        @(negedge clk);
        check_controls_low();
        errs_at_start = errors;
    endtask

    // Wait for exp_q.size() output bytes, then compare in order
    task automatic expect_bytes();
        int cycles;
        cycles = 0;
        while (out_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (out_q.size() < exp_q.size()) begin
            $display("Timeout waiting for output: %0d of %0d bytes arrived",
                     out_q.size(), exp_q.size());
            errors++;
        end
        // Quiet window catches extra bytes
        repeat (5) @(negedge clk);
        check_value("output byte count", 8'(out_q.size()), 8'(exp_q.size()));
        foreach (exp_q[i]) begin
            if (i < out_q.size()) check_value("out_data_o", out_q[i], exp_q[i]);
        end
        out_q.delete();
        exp_q.delete();
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished, %0d errors", tests, name, errors - errs_at_start);
    endtask

    // Error reply expected and then the FSM parks with test_fail_o set
    task automatic run_error_case(input string name);
        expect_bytes();
        check_value("test_fail_o", 8'(test_fail_o), 8'h01);
        finish_test(name);
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    initial begin
        // Loopback with every byte echoed then OK status
        apply_reset();
        in_q = '{8'h01, TEST_RECEIVE_SEND, make_header(CMD_TEST_DATA, 6),
                 8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, make_header(CMD_TEST_STOP, 0)};
        for (int i = 0; i < 6; i++) begin
            exp_q.push_back(make_header(CMD_TEST_DATA, 1));
            exp_q.push_back(8'(i));
        end
        exp_q.push_back(make_header(CMD_TEST_STOPPED, 1));
        exp_q.push_back(ERR_NONE);
        expect_bytes();
        check_value("test_ok_o", 8'(test_ok_o), 8'h01);
        finish_test("loopback");

        // Receive test with a bad third byte
        apply_reset();
        in_q = '{8'h01, TEST_RECEIVE, make_header(CMD_TEST_DATA, 3), 8'h00, 8'h01, 8'h09,
                 make_header(CMD_TEST_STOP, 0), 8'h01};
        exp_q = '{make_header(CMD_TEST_STOPPED, 3), ERR_TEST_DATA, 8'h09, 8'h02};
        expect_bytes();
        check_value("test_fail_o", 8'(test_fail_o), 8'h01);
        level = in_q.size();
        // Remaining input must stay unread
        repeat (20) begin
            @(negedge clk);
            check_value("in_rd_en_o", 8'(in_rd_en_o), 8'h00);
        end
        check_value("input FIFO level", 8'(in_q.size()), 8'(level));
        finish_test("receive mismatch");

        // Send test under random back-pressure
        apply_reset();
        random_full = 1'b1;
        in_q = '{8'h01, TEST_SEND};
        for (int i = 0; i < 8; i++) begin
            if (i % 4 == 0) exp_q.push_back(make_header(CMD_TEST_DATA, 4));
            exp_q.push_back(8'(i));
        end
        exp_q.push_back(make_header(CMD_TEST_STOPPED, 1));
        exp_q.push_back(ERR_NONE);
        expect_bytes();
        check_value("test_ok_o", 8'(test_ok_o), 8'h01);
        random_full = 1'b0;
        finish_test("send with back-pressure");

        // Protocol errors
        apply_reset();
        in_q = '{make_header(CMD_TEST_START, 2), TEST_RECEIVE, 8'h00};
        exp_q = '{make_header(CMD_TEST_STOPPED, 1), ERR_START_PAYLOAD};
        run_error_case("start length");
        apply_reset();
        in_q = '{make_header(CMD_TEST_STOP, 1), 8'h00};
        exp_q = '{make_header(CMD_TEST_STOPPED, 1), ERR_STOP_PAYLOAD};
        run_error_case("stop length");
        apply_reset();
        in_q = '{make_header(CMD_TEST_STOPPED, 0)};
        exp_q = '{make_header(CMD_TEST_STOPPED, 1), ERR_INVALID_CMD};
        run_error_case("invalid command");
        apply_reset();
        in_q = '{8'h01, 8'h07};
        exp_q = '{make_header(CMD_TEST_STOPPED, 2), ERR_TEST_NUM, 8'h07};
        run_error_case("unknown test number");

        // Idle controller takes a new test once reset
        apply_reset();
        in_q = '{8'h01, TEST_RECEIVE, make_header(CMD_TEST_DATA, 2), 8'h00, 8'h01,
                 make_header(CMD_TEST_STOP, 0)};
        exp_q = '{make_header(CMD_TEST_STOPPED, 1), ERR_NONE};
        expect_bytes();
        check_value("test_ok_o", 8'(test_ok_o), 8'h01);
        finish_test("restart after failure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
source/test_ctrl_pkg.sv
source/cmd_parser.sv
source/pattern_generator.sv
source/reply_writer.sv
source/test_controller.sv
bench/test_controller_assertions.sv
bench/test_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module test_controller_tb \
    --Mdir obj_dir

./obj_dir/Vtest_controller_tb | tee sim.log

# Pass only when the log holds the pass line
grep -q "Simulation PASSED" sim.log
echo "run_sim: simulation passed"

/* source/cmd_parser.sv */
// Input packet decoder with data checking, test result flags and reply building
`timescale 1ns/10ps

module cmd_parser (
    input  logic                                      clk,
    input  logic                                      reset_i,
    input  logic                                      in_empty_i,
    input  logic [7:0]                                in_data_i,
    output logic                                      in_rd_en_o,
    output logic                                      reply_valid_o,
    output logic [test_ctrl_pkg::REPLY_WORDS-1:0][7:0] reply_words_o,
    input  logic                                      reply_done_i,
    output logic                                      gen_start_o,
    input  logic                                      gen_done_i,
    output logic                                      test_ok_o,
    output logic                                      test_fail_o
);
    import test_ctrl_pkg::*;

    // FSM states
    localparam logic [1:0] ST_READ       = 2'd0;
    localparam logic [1:0] ST_WAIT_REPLY = 2'd1;
    localparam logic [1:0] ST_WAIT_GEN   = 2'd2;
    localparam logic [1:0] ST_IDLE       = 2'd3;

    logic [1:0]       state_q;
    logic             in_payload_q;
    logic [LEN_W-1:0] payload_left_q;
    logic [1:0]       last_cmd_q;
    logic [7:0]       expected_q;
    logic [7:0]       test_num_q;

    pkt_header_t hdr;
    pkt_header_t rep_hdr;
    logic [7:0]  rep_code;
    logic        take_hdr;
    logic        take_pay;
    logic        fail;
    logic        pass;
    logic        echo;
    logic        start_gen;
    logic        load_reply;

    // Byte taken in the same cycle the FIFO shows it
    assign in_rd_en_o = (state_q == ST_READ) && !in_empty_i;

    // ======================================================================
    // Decode of the current input byte
    // ======================================================================
    always_comb begin
        hdr.raw   = in_data_i;
        take_hdr  = in_rd_en_o && !in_payload_q;
        take_pay  = in_rd_en_o && in_payload_q;
        fail      = 1'b0;
        pass      = 1'b0;
        echo      = 1'b0;
        start_gen = 1'b0;
        // Status reply by default
        rep_hdr.f.cmd = CMD_TEST_STOPPED;
        rep_hdr.f.len = LEN_W'(1);
        rep_code      = ERR_NONE;

        if (take_hdr) begin
            case (hdr.f.cmd)
                CMD_TEST_START: begin
                    if (hdr.f.len != LEN_W'(1)) begin
                        fail     = 1'b1;
                        rep_code = ERR_START_PAYLOAD;
                    end
                end
                CMD_TEST_DATA: begin
                    // Payload bytes checked one by one
                end
                CMD_TEST_STOP: begin
                    if (hdr.f.len == '0) begin
                        pass = 1'b1;
                    end else begin
                        fail     = 1'b1;
                        rep_code = ERR_STOP_PAYLOAD;
                    end
                end
                default: begin
                    fail     = 1'b1;
                    rep_code = ERR_INVALID_CMD;
                end
            endcase
        end

        // Test number of a START packet
        if (take_pay && last_cmd_q == CMD_TEST_START) begin
            case (in_data_i)
                TEST_SEND: start_gen = 1'b1;
                TEST_RECEIVE, TEST_RECEIVE_SEND: begin
                    // Nothing until data arrives
                end
                default: begin
                    fail          = 1'b1;
                    rep_hdr.f.len = LEN_W'(2);
                    rep_code      = ERR_TEST_NUM;
                end
            endcase
        end

        // Data byte against the expected count
        if (take_pay && last_cmd_q == CMD_TEST_DATA) begin
            if (in_data_i != expected_q) begin
                fail          = 1'b1;
                rep_hdr.f.len = LEN_W'(3);
                rep_code      = ERR_TEST_DATA;
            end else if (test_num_q == TEST_RECEIVE_SEND) begin
                // Echo as a DATA packet of one byte
                echo          = 1'b1;
                rep_hdr.f.cmd = CMD_TEST_DATA;
                rep_code      = in_data_i;
            end
        end

        // Send test finished
        if (state_q == ST_WAIT_GEN && gen_done_i) begin
            pass = 1'b1;
        end

        load_reply = fail || pass || echo;
    end

    // ======================================================================
    // Control state
    // ======================================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q        <= ST_READ;
            in_payload_q   <= 1'b0;
            payload_left_q <= '0;
            last_cmd_q     <= CMD_TEST_START;
            expected_q     <= 8'd0;
            test_num_q     <= 8'd0;
            reply_valid_o  <= 1'b0;
            gen_start_o    <= 1'b0;
            test_ok_o      <= 1'b0;
            test_fail_o    <= 1'b0;
        end else begin
            gen_start_o <= 1'b0;
            if (take_hdr) begin
                last_cmd_q <= hdr.f.cmd;
                if (hdr.f.len != '0) begin
                    in_payload_q   <= 1'b1;
                    payload_left_q <= hdr.f.len;
                end
                // New test clears the result flags
                if (hdr.f.cmd == CMD_TEST_START) begin
                    test_ok_o   <= 1'b0;
                    test_fail_o <= 1'b0;
                    expected_q  <= 8'd0;
                end
            end
            if (take_pay) begin
                payload_left_q <= payload_left_q - LEN_W'(1);
                if (payload_left_q == LEN_W'(1)) begin
                    in_payload_q <= 1'b0;
                end
                if (last_cmd_q == CMD_TEST_START) begin
                    test_num_q <= in_data_i;
                end
                if (last_cmd_q == CMD_TEST_DATA) begin
                    expected_q <= expected_q + 8'd1;
                end
            end
            if (start_gen) begin
                gen_start_o <= 1'b1;
                state_q     <= ST_WAIT_GEN;
            end
            if (load_reply) begin
                reply_valid_o <= 1'b1;
                state_q       <= ST_WAIT_REPLY;
            end
            if (pass) test_ok_o <= 1'b1;
            // A failure replaces an earlier OK result
            if (fail) begin
                test_ok_o   <= 1'b0;
                test_fail_o <= 1'b1;
            end
            // Failure parks the FSM until reset
            if (reply_done_i) begin
                reply_valid_o <= 1'b0;
                state_q       <= test_fail_o ? ST_IDLE : ST_READ;
            end
        end
    end

    // Tail bytes of the reply only matter for error replies
    always_ff @(posedge clk) begin
        if (load_reply) begin
            reply_words_o[0] <= rep_hdr.raw;
            reply_words_o[1] <= rep_code;
            reply_words_o[2] <= in_data_i;
            reply_words_o[3] <= expected_q;
        end
    end

endmodule

/* source/pattern_generator.sv */
// Send test packet source with header and counting payload bytes
`timescale 1ns/10ps

module pattern_generator #(
    parameter int PAYLOAD_LEN  = 63,
    parameter int PACKET_COUNT = 1
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       gen_start_i,
    input  logic       gen_ready_i,
    output logic       gen_valid_o,
    output logic [7:0] gen_byte_o,
    output logic       gen_done_o
);
    import test_ctrl_pkg::*;

    localparam int CNT_W = $clog2(PACKET_COUNT + 1);

    logic             in_header_q;
    logic [LEN_W-1:0] bytes_left_q;
    logic [CNT_W-1:0] pkts_left_q;
    logic [7:0]       data_q;
    logic             accept;

    assign accept = gen_valid_o && gen_ready_i;

    // Header first, then the running count
    assign gen_byte_o = in_header_q ? {CMD_TEST_DATA, LEN_W'(PAYLOAD_LEN)} : data_q;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            gen_valid_o  <= 1'b0;
            gen_done_o   <= 1'b0;
            in_header_q  <= 1'b0;
            bytes_left_q <= '0;
            pkts_left_q  <= '0;
            data_q       <= 8'd0;
        end else begin
            gen_done_o <= 1'b0;
            if (gen_start_i) begin
                // Count restarts at zero for every test
                gen_valid_o  <= 1'b1;
                in_header_q  <= 1'b1;
                bytes_left_q <= LEN_W'(PAYLOAD_LEN);
                pkts_left_q  <= CNT_W'(PACKET_COUNT);
                data_q       <= 8'd0;
            end else if (accept) begin
                if (in_header_q) begin
                    in_header_q <= 1'b0;
                end else begin
                    data_q       <= data_q + 8'd1;
                    bytes_left_q <= bytes_left_q - LEN_W'(1);
                    if (bytes_left_q == LEN_W'(1)) begin
                        if (pkts_left_q == CNT_W'(1)) begin
                            // Last byte of last packet
                            gen_valid_o <= 1'b0;
                            gen_done_o  <= 1'b1;
                        end else begin
                            pkts_left_q  <= pkts_left_q - CNT_W'(1);
                            bytes_left_q <= LEN_W'(PAYLOAD_LEN);
                            in_header_q  <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

/* source/reply_writer.sv */
// Output FIFO write arbiter for parser replies and generator bytes
`timescale 1ns/10ps

module reply_writer (
    input  logic                                      clk,
    input  logic                                      reset_i,
    input  logic                                      reply_valid_i,
    input  logic [test_ctrl_pkg::REPLY_WORDS-1:0][7:0] reply_words_i,
    output logic                                      reply_done_o,
    input  logic                                      gen_valid_i,
    input  logic [7:0]                                gen_byte_i,
    output logic                                      gen_ready_o,
    input  logic                                      out_full_i,
    output logic                                      out_wr_en_o,
    output logic [7:0]                                out_data_o
);
    import test_ctrl_pkg::*;

    localparam int IDX_W = $clog2(REPLY_WORDS);

    pkt_header_t      hdr;
    logic [IDX_W-1:0] idx_q;
    logic             reply_active;
    logic             reply_last;

    // Length comes from the header view of word 0
    assign hdr.raw = reply_words_i[0];

    // Reply is finished while the done pulse is out
    assign reply_active = reply_valid_i && !reply_done_o;
    assign reply_last   = (hdr.f.len == LEN_W'(idx_q));

    // ======================================================================
    // Output FIFO write port
    // ======================================================================

    // Generator only gets the port when no reply is active
    assign gen_ready_o = !out_full_i && !reply_active;
    assign out_wr_en_o = !out_full_i && (reply_active || gen_valid_i);
    assign out_data_o  = reply_active ? reply_words_i[idx_q] : gen_byte_i;

    // Word index and done pulse
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            idx_q        <= '0;
            reply_done_o <= 1'b0;
        end else begin
            reply_done_o <= 1'b0;
            if (reply_active && !out_full_i) begin
                if (reply_last) begin
                    idx_q        <= '0;
                    reply_done_o <= 1'b1;
                end else begin
                    idx_q <= idx_q + IDX_W'(1);
                end
            end
        end
    end

endmodule

/* source/test_controller.sv */
// Top level of the link test controller wiring parser, generator and writer
`timescale 1ns/10ps

module test_controller #(
    parameter int PAYLOAD_LEN  = 63,
    parameter int PACKET_COUNT = 1
) (
    input  logic       clk,
    input  logic       reset_i,
    // Input FIFO, data shown before the read
    input  logic       in_empty_i,
    input  logic [7:0] in_data_i,
    output logic       in_rd_en_o,
    // Output FIFO
    input  logic       out_full_i,
    output logic       out_wr_en_o,
    output logic [7:0] out_data_o,
    // Test result
    output logic       test_ok_o,
    output logic       test_fail_o
);
    import test_ctrl_pkg::*;

    logic                        reply_valid;
    logic [REPLY_WORDS-1:0][7:0] reply_words;
    logic                        reply_done;
    logic                        gen_start;
    logic                        gen_done;
    logic                        gen_valid;
    logic                        gen_ready;
    logic [7:0]                  gen_byte;

    // ======================================================================
    // Blocks
    // ======================================================================

    cmd_parser cmd_parser_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_empty_i    (in_empty_i),
        .in_data_i     (in_data_i),
        .in_rd_en_o    (in_rd_en_o),
        .reply_valid_o (reply_valid),
        .reply_words_o (reply_words),
        .reply_done_i  (reply_done),
        .gen_start_o   (gen_start),
        .gen_done_i    (gen_done),
        .test_ok_o     (test_ok_o),
        .test_fail_o   (test_fail_o)
    );

    pattern_generator #(
        .PAYLOAD_LEN  (PAYLOAD_LEN),
        .PACKET_COUNT (PACKET_COUNT)
    ) pattern_generator_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .gen_start_i (gen_start),
        .gen_ready_i (gen_ready),
        .gen_valid_o (gen_valid),
        .gen_byte_o  (gen_byte),
        .gen_done_o  (gen_done)
    );

    reply_writer reply_writer_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .reply_valid_i (reply_valid),
        .reply_words_i (reply_words),
        .reply_done_o  (reply_done),
        .gen_valid_i   (gen_valid),
        .gen_byte_i    (gen_byte),
        .gen_ready_o   (gen_ready),
        .out_full_i    (out_full_i),
        .out_wr_en_o   (out_wr_en_o),
        .out_data_o    (out_data_o)
    );

endmodule

/* source/test_ctrl_pkg.sv */
// Shared constants and header type for the byte-stream link test controller
package test_ctrl_pkg;

    // ======================================================================
    // Packet header layout
    // ======================================================================

    // Payload length field, low bits of every header byte
    localparam int LEN_W = 6;

    // Reply buffer depth: header plus up to three payload bytes
    localparam int REPLY_WORDS = 4;

    // Command codes, upper two bits of a header
    localparam logic [1:0] CMD_TEST_START   = 2'd0;
    localparam logic [1:0] CMD_TEST_DATA    = 2'd1;
    localparam logic [1:0] CMD_TEST_STOP    = 2'd2;
    // Sent by the controller only; invalid on the input side
    localparam logic [1:0] CMD_TEST_STOPPED = 2'd3;

    // ======================================================================
    // Test numbers, payload byte of a START packet
    // ======================================================================

    // Incoming data must count up from zero
    localparam logic [7:0] TEST_RECEIVE      = 8'd1;
    // Controller generates counting packets
    localparam logic [7:0] TEST_SEND         = 8'd2;
    // Check and echo every data byte
    localparam logic [7:0] TEST_RECEIVE_SEND = 8'd3;

    // ======================================================================
    // Error codes, first payload byte of a STOPPED packet
    // ======================================================================

    localparam logic [7:0] ERR_NONE          = 8'd0;
    // START length not 1
    localparam logic [7:0] ERR_START_PAYLOAD = 8'd1;
    // STOP length not 0
    localparam logic [7:0] ERR_STOP_PAYLOAD  = 8'd2;
    // STOPPED received as a command
    localparam logic [7:0] ERR_INVALID_CMD   = 8'd3;
    // Unknown test number, followed by that number
    localparam logic [7:0] ERR_TEST_NUM      = 8'd4;
    // Data mismatch, followed by received and expected bytes
    localparam logic [7:0] ERR_TEST_DATA     = 8'd5;

    // Header byte, seen either whole or as command plus length
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0]       cmd;
            logic [LEN_W-1:0] len;
        } f;
    } pkt_header_t;

endpackage
